//--- common/firPkg.sv
package firPkg;

`include "fir_cfg.svh"

	// Tap count as a package constant, so the RTL can size its arrays from it.
	localparam int unsigned firTaps = `FIR_TAPS;

	// Data types shared by every block and by the testbench model.
	typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;
	typedef logic signed [`FIR_DATA_WIDTH-1:0] coeff_t;
	typedef logic signed [`FIR_ACC_WIDTH-1:0] acc_t;
	typedef logic [$clog2(`FIR_TAPS)-1:0] tapIndex_t;

	// Index of the last tap, where the loader and the core both stop counting.
	localparam tapIndex_t lastTap = tapIndex_t'(firTaps - 1);

	// Fixed coefficients, tap 0 first. Tap 0 multiplies the newest sample.
	localparam coeff_t firCoeffTable [firTaps] = '{34, 34, 0, 49, 125, -77, -51, 8, 98, 109,
		-91, -3, 9, 1, 59, 75, 19, 58, -97, 10};

	// Coefficient loader states.
	typedef enum logic [1:0] {loaderIdle, loaderStreaming, loaderDone} loaderState_e;

	// Filter core states.
	typedef enum logic [1:0] {coreWaitCoeffs, coreIdle, coreAccumulate, coreHold} coreState_e;

	// Four-phase side states. The receiver uses the first two, the sender the last two.
	typedef enum logic [1:0] {hsIdle, hsReqHigh, hsPresent, hsWaitRelease} hsState_e;

endpackage

//--- common/fir_cfg.svh
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// Number of taps in the filter.
`define FIR_TAPS 20

// Width of the input samples and of the coefficients.
`define FIR_DATA_WIDTH 8

// A full product needs twice the data width.
// The sum of all taps adds enough growth bits to count them.
// This comes to 21 bits for 20 taps of 8 by 8.
`define FIR_ACC_WIDTH (2 * `FIR_DATA_WIDTH + $clog2(`FIR_TAPS))

`endif

//--- firCore/coeffLoader.sv
module coeffLoader import firPkg::*; (
	input logic clock,
	input logic rst,
	output logic coeffValid,
	output coeff_t coeffData,
	output logic coeffsSet
);

	// Loader state and position in the coefficient table.
	loaderState_e state;
	tapIndex_t coeffIndex;

	// The idle state covers the single cycle that follows reset.
	// Streaming then starts by itself, since the end of reset is the only trigger.
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= loaderIdle;
			coeffIndex <= '0;
			coeffsSet <= 1'b0;
		end else begin
			case (state)
				loaderIdle: begin
					state <= loaderStreaming;
					coeffIndex <= '0;
				end
				loaderStreaming: begin
					// The last coefficient is on the bus in this cycle.
					// The flag rises with the next edge and stays up until reset.
					if (coeffIndex == lastTap) begin
						state <= loaderDone;
						coeffsSet <= 1'b1;
					end else begin
						coeffIndex <= coeffIndex + 1'b1;
					end
				end
				loaderDone: begin
					coeffsSet <= 1'b1;
				end
				default: begin
					state <= loaderIdle;
				end
			endcase
		end
	end

	// One coefficient is shown per streaming cycle, read straight from the table.
	assign coeffValid = (state == loaderStreaming);
	assign coeffData = firCoeffTable[coeffIndex];

endmodule

//--- firCore/firCore.sv
module firCore import firPkg::*; (
	input logic clock,
	input logic rst,
	input logic coeffValid,
	input coeff_t coeffData,
	input logic coeffsSet,
	input logic sampleValid,
	input sample_t sampleData,
	output logic sampleReady,
	output logic resultValid,
	output acc_t resultData,
	input logic resultReady
);

	coreState_e state;

	// Coefficient store, filled by the loader. Entry k holds coefficient k.
	coeff_t coeffStore [firTaps];

	// Sample delay line. Entry 0 holds the newest sample.
	sample_t delayLine [firTaps];

	// Tap being multiplied in the current accumulate cycle.
	tapIndex_t tapCount;

	// Running sum and the product added to it in this cycle.
	acc_t acc;
	acc_t product;

	logic sampleAccept;

	// A sample is taken only in idle, so one sample at a time is in flight.
	assign sampleReady = (state == coreIdle);
	assign sampleAccept = sampleValid && sampleReady;

	// The result is offered until the sender takes it.
	assign resultValid = (state == coreHold);
	assign resultData = acc;

	// Both factors are sign extended to the accumulator width before multiplying.
	assign product = acc_t'(coeffStore[tapCount]) * acc_t'(delayLine[tapCount]);

	// Coefficients arrive in table order and shift down from the top entry.
	// After the full stream coefficient 0 sits in entry 0.
	always_ff @(posedge clock) begin
		if (coeffValid) begin
			for (int i = 0; i < firTaps - 1; i++) begin
				coeffStore[i] <= coeffStore[i + 1];
			end
			coeffStore[firTaps - 1] <= coeffData;
		end
	end

	// Each accepted sample pushes the older ones one tap further back.
	// Reset empties the line, so earlier history counts as zero.
	always_ff @(posedge clock) begin
		if (rst) begin
			delayLine <= '{default: '0};
		end else if (sampleAccept) begin
			delayLine[0] <= sampleData;
			for (int i = 1; i < firTaps; i++) begin
				delayLine[i] <= delayLine[i - 1];
			end
		end
	end

	// The sum restarts with every new sample and takes one tap per cycle.
	always_ff @(posedge clock) begin
		if (sampleAccept) begin
			acc <= '0;
		end else if (state == coreAccumulate) begin
			acc <= acc + product;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= coreWaitCoeffs;
			tapCount <= '0;
		end else begin
			case (state)
				coreWaitCoeffs: begin
					if (coeffsSet) begin
						state <= coreIdle;
					end
				end
				coreIdle: begin
					tapCount <= '0;
					if (sampleValid) begin
						state <= coreAccumulate;
					end
				end
				coreAccumulate: begin
					// The last product lands in the sum with the same edge that enters hold.
					if (tapCount == lastTap) begin
						state <= coreHold;
					end else begin
						tapCount <= tapCount + 1'b1;
					end
				end
				coreHold: begin
					if (resultReady) begin
						state <= coreIdle;
					end
				end
				default: begin
					state <= coreWaitCoeffs;
				end
			endcase
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Builds the FIR testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module firFilterTb -f tb.f -o firFilterSim

./obj_dir/firFilterSim | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
	echo "Simulation run passed"
else
	echo "Simulation run failed"
	exit 1
fi

//--- source/firFilterTop.sv
module firFilterTop import firPkg::*; (
	input logic clock,
	input logic rst,
	input logic inReq,
	input sample_t inData,
	output logic inAck,
	output logic outReq,
	output acc_t outData,
	input logic outAck
);

	// Loader to core.
	logic coeffValid;
	coeff_t coeffData;
	logic coeffsSet;

	// Receiver to core.
	logic sampleValid;
	sample_t sampleData;
	logic sampleReady;

	// Core to sender.
	logic resultValid;
	acc_t resultData;
	logic resultReady;

	// Input side. It can hold the next sample while the core is still busy.
	sampleReceiver receiver_i (
		.clock(clock),
		.rst(rst),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.sampleReady(sampleReady)
	);

	// Coefficients stream in once after every reset.
	coeffLoader loader_i (
		.clock(clock),
		.rst(rst),
		.coeffValid(coeffValid),
		.coeffData(coeffData),
		.coeffsSet(coeffsSet)
	);

	firCore core_i (
		.clock(clock),
		.rst(rst),
		.coeffValid(coeffValid),
		.coeffData(coeffData),
		.coeffsSet(coeffsSet),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.sampleReady(sampleReady),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultReady(resultReady)
	);

	// Output side. A slow consumer stalls the core through resultReady.
	resultSender sender_i (
		.clock(clock),
		.rst(rst),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultReady(resultReady),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

endmodule

//--- source/resultSender.sv
module resultSender import firPkg::*; (
	input logic clock,
	input logic rst,
	input logic resultValid,
	input acc_t resultData,
	output logic resultReady,
	output logic outReq,
	output acc_t outData,
	input logic outAck
);

	hsState_e state;

	// The waitRelease state doubles as the ready state once outAck is low.
	// A new result is refused while the previous ack is still high.
	assign resultReady = (state == hsWaitRelease) && !outAck;
	assign outReq = (state == hsPresent);

	// outData only loads on a transfer, and no transfer happens while outReq is high.
	always_ff @(posedge clock) begin
		if (resultValid && resultReady) begin
			outData <= resultData;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= hsWaitRelease;
		end else begin
			case (state)
				hsWaitRelease: begin
					if (resultValid && resultReady) begin
						state <= hsPresent;
					end
				end
				hsPresent: begin
					// The consumer has the data, so drop the request.
					if (outAck) begin
						state <= hsWaitRelease;
					end
				end
				default: begin
					state <= hsWaitRelease;
				end
			endcase
		end
	end

endmodule

//--- source/sampleReceiver.sv
module sampleReceiver import firPkg::*; (
	input logic clock,
	input logic rst,
	input logic inReq,
	input sample_t inData,
	output logic inAck,
	output logic sampleValid,
	output sample_t sampleData,
	input logic sampleReady
);

	hsState_e state;

	// The sample register is loaded only on a new request.
	// It holds its value until the next request.
	always_ff @(posedge clock) begin
		if ((state == hsIdle) && inReq) begin
			sampleData <= inData;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= hsIdle;
			sampleValid <= 1'b0;
			inAck <= 1'b0;
		end else begin
			case (state)
				hsIdle: begin
					// A new request. The data is stable while inReq is high.
					if (inReq) begin
						sampleValid <= 1'b1;
						state <= hsReqHigh;
					end
				end
				hsReqHigh: begin
					// Acknowledge only once the core has taken the sample.
					// A busy core therefore holds back inAck.
					if (sampleValid && sampleReady) begin
						sampleValid <= 1'b0;
						inAck <= 1'b1;
					end
					// The producer has seen the ack and released the request.
					if (inAck && !inReq) begin
						inAck <= 1'b0;
						state <= hsIdle;
					end
				end
				default: begin
					state <= hsIdle;
					sampleValid <= 1'b0;
					inAck <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- tb.f
+incdir+common
common/firPkg.sv
firCore/coeffLoader.sv
firCore/firCore.sv
source/sampleReceiver.sv
source/resultSender.sv
source/firFilterTop.sv
test/firFilter_checker.sv
test/firFilterTb.sv

//--- test/firFilterTb.sv
`include "fir_cfg.svh"

module firFilterTb import firPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// Stream lengths of the directed tests.
	localparam int stepLen = `FIR_TAPS + 5;
	localparam int randomLen = 60;
	localparam int pressureLen = 40;
	localparam int maxAckDelay = 30;
	// The consumer may keep outAck up for a few cycles after outReq has fallen.
	localparam int maxReleaseDelay = 3;
	// The last four are the three samples before the second reset and the one it cuts off.
	localparam int totalSamples = 2 * `FIR_TAPS + stepLen + randomLen + pressureLen + 4;
	// Each sample gets FIR_TAPS+10 cycles, and the slow consumer adds its own delays on top.
	localparam int watchdogCycles = totalSamples * (`FIR_TAPS + 10)
		+ pressureLen * (maxAckDelay + maxReleaseDelay) + 1000;
	// A single handshake phase that takes longer than this is stuck.
	localparam int stallLimit = 200;

	logic clock;
	logic rst;
	logic inReq;
	sample_t inData;
	logic inAck;
	logic outReq;
	acc_t outData;
	logic outAck;

	int errorCount;

	// Reference model state. Entry k holds the input from k samples ago.
	sample_t history [firTaps];
	acc_t expectedQ [$];

	firFilterTop dut_i (
		.clock(clock),
		.rst(rst),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

	bind firFilterTop firFilter_checker checker_i (
		.clock(clock),
		.rst(rst),
		.inReq(inReq),
		.inAck(inAck),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

	always #50 clock = ~clock;

	// The FIR sum is formed in plain integers, wide enough for any input.
	function automatic acc_t modelStep(sample_t x);
		int sum;
		for (int k = firTaps - 1; k > 0; k--) begin
			history[k] = history[k - 1];
		end
		history[0] = x;
		sum = 0;
		for (int k = 0; k < firTaps; k++) begin
			sum += int'(firCoeffTable[k]) * int'(history[k]);
		end
		return acc_t'(sum);
	endfunction

	task automatic compareResult(acc_t expected, acc_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL outData expected %h actual %h", expected, actual);
		end
	endtask

	task automatic compareHandshake(string what, logic expected, logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Handshake error: %s", what);
		end
	endtask

	// Resets the DUT for two cycles and empties the model with it.
	task automatic applyReset();
		rst = 1'b1;
		inReq = 1'b0;
		outAck = 1'b0;
		repeat (2) begin
			@(posedge clock);
			#10;
		end
		rst = 1'b0;
		foreach (history[k]) begin
			history[k] = '0;
		end
		expectedQ.delete();
	endtask

	// Producer side of the input port. It is called 10 ns after a rising edge.
	task automatic sendSample(sample_t value);
		int cycles;
		expectedQ.push_back(modelStep(value));
		inData = value;
		inReq = 1'b1;
		cycles = 0;
		while (!inAck && cycles < stallLimit) begin
			@(posedge clock);
			#10;
			cycles++;
		end
		compareHandshake("inAck never rose", 1'b1, inAck);
		inReq = 1'b0;
		cycles = 0;
		while (inAck && cycles < stallLimit) begin
			@(posedge clock);
			#10;
			cycles++;
		end
		compareHandshake("inAck stuck high after inReq fell", 1'b0, inAck);
	endtask

	// Consumer side of the output port, with ackDelay cycles before outAck.
	// After outReq falls, outAck stays up for releaseDelay more cycles.
	task automatic takeResult(int ackDelay, int releaseDelay);
		int cycles;
		acc_t expected;
		cycles = 0;
		while (!outReq && cycles < stallLimit) begin
			@(posedge clock);
			#10;
			cycles++;
		end
		compareHandshake("outReq never rose", 1'b1, outReq);
		if (outReq) begin
			repeat (ackDelay) begin
				@(posedge clock);
				#10;
			end
			if (expectedQ.size() == 0) begin
				errorCount++;
				$display("A result arrived with no sample outstanding");
			end else begin
				expected = expectedQ.pop_front();
				compareResult(expected, outData);
			end
			outAck = 1'b1;
			cycles = 0;
			while (outReq && cycles < stallLimit) begin
				@(posedge clock);
				#10;
				cycles++;
			end
			compareHandshake("outReq stuck high after outAck", 1'b0, outReq);
			// The sender must not present the next result while outAck is still high.
			repeat (releaseDelay) begin
				@(posedge clock);
				#10;
			end
			outAck = 1'b0;
		end
	endtask

	// Producer and consumer run side by side, so the receiver can hold the next sample.
	task automatic runStream(sample_t samples[$], int maxDelay);
		fork
			foreach (samples[i]) begin
				sendSample(samples[i]);
			end
			for (int i = 0; i < samples.size(); i++) begin
				takeResult((maxDelay == 0) ? 0 : int'($urandom_range(maxDelay)),
					(maxDelay == 0) ? 0 : int'($urandom_range(maxReleaseDelay)));
			end
		join
		compareHandshake("results missing at the end of a stream", 1'b1, expectedQ.size() == 0);
		// A repeated result would show up as a late outReq here.
		repeat (firTaps + 5) begin
			@(posedge clock);
			#10;
		end
		compareHandshake("extra outReq after a stream", 1'b0, outReq);
	endtask

	task automatic impulseTest();
		sample_t stream [$];
		stream.push_back(sample_t'(1));
		repeat (firTaps - 1) begin
			stream.push_back(sample_t'(0));
		end
		runStream(stream, 0);
	endtask

	task automatic stepTest();
		sample_t stream [$];
		repeat (stepLen) begin
			stream.push_back(sample_t'(5));
		end
		runStream(stream, 0);
	endtask

	task automatic randomTest();
		sample_t stream [$];
		for (int i = 0; i < randomLen; i++) begin
			stream.push_back(sample_t'($urandom()));
		end
		// Both ends of the sample range, next to each other in the delay line.
		stream[10] = sample_t'(-128);
		stream[11] = sample_t'(127);
		runStream(stream, 0);
	endtask

	task automatic backPressureTest();
		sample_t stream [$];
		for (int i = 0; i < pressureLen; i++) begin
			stream.push_back(sample_t'($urandom()));
		end
		runStream(stream, maxAckDelay);
	endtask

	task automatic resetTest();
		sample_t stream [$];
		repeat (3) begin
			stream.push_back(sample_t'($urandom()));
		end
		runStream(stream, 2);
		// This sample reaches the core and is lost in the middle of its sum.
		sendSample(sample_t'(100));
		repeat (5) begin
			@(posedge clock);
			#10;
		end
		applyReset();
		compareHandshake("outReq high after the second reset", 1'b0, outReq);
		compareHandshake("inAck high after the second reset", 1'b0, inAck);
		impulseTest();
	endtask

	initial begin
		void'($urandom(17));
		errorCount = 0;
		clock = 1'b0;
		rst = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		applyReset();
		impulseTest();
		stepTest();
		randomTest();
		backPressureTest();
		resetTest();
		$display("Errors: %0d", errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Ends a run that hangs somewhere in a handshake.
	initial begin
		repeat (watchdogCycles) begin
			@(posedge clock);
		end
		$display("Watchdog: the tests did not finish within %0d cycles", watchdogCycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- test/firFilter_checker.sv
module firFilter_checker import firPkg::*; (
	input logic clock,
	input logic rst,
	input logic inReq,
	input logic inAck,
	input logic outReq,
	input acc_t outData,
	input logic outAck
);

	timeunit 1ns;
	timeprecision 100ps;

	// A presented result stays on the port, unchanged, until the consumer acknowledges it.
	outReqHeld: assert property (@(posedge clock) disable iff (rst)
		outReq && !outAck |=> outReq && $stable(outData))
		else $error("outReq fell or outData changed before outAck");

	// The receiver acknowledges only a request that was already there.
	inAckNeedsReq: assert property (@(posedge clock) disable iff (rst)
		$rose(inAck) |-> $past(inReq))
		else $error("inAck rose without an inReq");

	// A new request waits until the ack of the last one has gone.
	noReqDuringAck: assert property (@(posedge clock) disable iff (rst)
		!outReq && outAck |=> !outReq)
		else $error("outReq rose while outAck was still high");

endmodule
